/* hdl/ddr_timing_pkg.sv */
// Shared command codes, delay codes and timing constants for the bank scheduler
// All cycle constants are in controller clock cycles
// Counter widths must hold the largest load value (write BL8, 15 cycles)
// Row-active width covers CYCLE_TRAS minus one only

package ddr_timing_pkg;

  ////////////////////////////////////////////////////////////
  // Command and delay encodings
  ////////////////////////////////////////////////////////////

  // DDR command as seen by the scheduler
  typedef enum logic [1:0] {
    CMD_ACT = 2'd0,
    CMD_RD  = 2'd1,
    CMD_WR  = 2'd2,
    CMD_PRE = 2'd3
  } ddr_cmd_t;

  // Which delay a bank timer is currently running
  typedef enum logic [2:0] {
    CODE_NONE                 = 3'd0,
    CODE_WRITE_TO_PRECHARGE   = 3'd1,
    CODE_PRECHARGE_TO_ACTIVE  = 3'd2,
    CODE_ACTIVE_TO_READ_WRITE = 3'd3,
    CODE_READ_TO_PRECHARGE    = 3'd4
  } delay_code_t;

  ////////////////////////////////////////////////////////////
  // Timing in cycles
  ////////////////////////////////////////////////////////////

  parameter int CYCLE_TRCD = 4;   // Activate to read or write
  parameter int CYCLE_TRTP = 3;   // Read to precharge
  parameter int CYCLE_TRP  = 4;   // Precharge period
  parameter int CYCLE_TWR  = 6;   // Write recovery
  parameter int CYCLE_WL   = 5;   // Write latency
  parameter int CYCLE_TRAS = 12;  // Activate to precharge minimum

  // Counter widths
  parameter int CNT_BITS = 5;
  parameter int RAS_BITS = 4;

  // APB register map
  parameter logic [3:0] ADDR_CMD    = 4'h0;
  parameter logic [3:0] ADDR_STATUS = 4'h4;

endpackage

/* hdl/ddr_apb_cmd_port.sv */
// APB slave front end of the bank scheduler
// Holds exactly one pending command; a command write stalls with wait states
// until the issue gate grants or rejects it
// Command fields: [1:0] command, [6:4] bank, [8] burst chop
// Bank field supports up to 8 banks
// Reads complete without wait states; unmapped writes complete with no effect

`timescale 1ns/1ps

module ddr_apb_cmd_port #(
  parameter int NUM_BANKS = 8
) (
  input  logic                                clk,
  input  logic                                rst_n,
  // APB slave
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [3:0]                          paddr,
  input  logic [31:0]                         pwdata,
  output logic [31:0]                         prdata,
  output logic                                pready,
  output logic                                pslverr,
  // Decision from the issue gate
  input  logic                                grant,
  input  logic                                reject,
  // Issued-command count from the driver
  input  logic [15:0]                         issue_count,
  // Pending command
  output logic                                req_valid,
  output ddr_timing_pkg::ddr_cmd_t            req_cmd,
  output logic [$clog2(NUM_BANKS)-1:0]        req_bank,
  output logic                                req_bc4
);

  localparam int BANK_BITS = $clog2(NUM_BANKS);

  logic access;
  logic cmd_wr;
  logic status_rd;
  logic capture;

  ////////////////////////////////////////////////////////////
  // Access decode
  ////////////////////////////////////////////////////////////

  // Access phase of any transfer
  assign access = psel && penable;

  // Command register write
  assign cmd_wr = access && pwrite && (paddr == ddr_timing_pkg::ADDR_CMD);

  // Status register read
  assign status_rd = access && !pwrite && (paddr == ddr_timing_pkg::ADDR_STATUS);

  // First access cycle of a command write, nothing pending yet
  assign capture = cmd_wr && !req_valid;

  ////////////////////////////////////////////////////////////
  // Pending command
  ////////////////////////////////////////////////////////////

  // Valid flag, set on capture and cleared on the gate decision
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      req_valid <= 1'b0;
    end else if (capture) begin
      req_valid <= 1'b1;
    end else if (grant || reject) begin
      req_valid <= 1'b0;
    end
  end

  // Command fields, only meaningful while req_valid is high
  always_ff @(posedge clk) begin
    if (capture) begin
      req_cmd  <= ddr_timing_pkg::ddr_cmd_t'(pwdata[1:0]);
      req_bank <= pwdata[4 +: BANK_BITS];
      req_bc4  <= pwdata[8];
    end
  end

  ////////////////////////////////////////////////////////////
  // Transfer completion and read data
  ////////////////////////////////////////////////////////////

  // Command writes wait for the gate
  // Every other access finishes in its first access cycle
  assign pready = (access && !cmd_wr) || grant || reject;

  // Error only for a rejected command
  assign pslverr = reject;

  // Status word: pending flag on top, issue count at the bottom
  always_comb begin
    prdata = '0;
    if (status_rd) begin
      prdata = {req_valid, 15'd0, issue_count};
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // A pending command only leaves through a gate decision
  a_req_release : assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(req_valid) |-> $past(grant || reject)
  );

endmodule

/* hdl/bank_timer.sv */
// Per-bank timing counter
// Load carries the bank match already; one instance per bank
// Command delay counter loads delay minus one, counts down, holds at zero
// Row-active counter loads only on activate and gates precharge
// Delay code keeps the last command's constraint until the next load

`timescale 1ns/1ps

module bank_timer (
  input  logic                             clk,
  input  logic                             rst_n,
  input  logic                             load,
  input  ddr_timing_pkg::ddr_cmd_t         cmd,
  input  logic                             bc4,
  output logic                             ready,
  output logic                             ras_done,
  output ddr_timing_pkg::delay_code_t      delay_code
);

  localparam int CW = ddr_timing_pkg::CNT_BITS;
  localparam int RW = ddr_timing_pkg::RAS_BITS;

  ////////////////////////////////////////////////////////////
  // Load values, already reduced by one
  ////////////////////////////////////////////////////////////

  localparam logic [CW-1:0] LD_ACT = CW'(ddr_timing_pkg::CYCLE_TRCD - 1);
  localparam logic [CW-1:0] LD_RD  = CW'(ddr_timing_pkg::CYCLE_TRTP - 1);
  localparam logic [CW-1:0] LD_PRE = CW'(ddr_timing_pkg::CYCLE_TRP - 1);
  // Write: latency plus burst plus recovery
  localparam logic [CW-1:0] LD_WR_BL8 =
    CW'(ddr_timing_pkg::CYCLE_WL + 4 + ddr_timing_pkg::CYCLE_TWR - 1);
  localparam logic [CW-1:0] LD_WR_BC4 =
    CW'(ddr_timing_pkg::CYCLE_WL + 2 + ddr_timing_pkg::CYCLE_TWR - 1);
  localparam logic [RW-1:0] LD_RAS = RW'(ddr_timing_pkg::CYCLE_TRAS - 1);

  logic [CW-1:0] cnt;
  logic [CW-1:0] load_val;
  logic [RW-1:0] ras_cnt;

  // Delay for the command being issued
  always_comb begin
    case (cmd)
      ddr_timing_pkg::CMD_ACT: load_val = LD_ACT;
      ddr_timing_pkg::CMD_RD:  load_val = LD_RD;
      ddr_timing_pkg::CMD_WR:  load_val = bc4 ? LD_WR_BC4 : LD_WR_BL8;
      default:                 load_val = LD_PRE;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Counters
  ////////////////////////////////////////////////////////////

  // Command-to-command delay, saturating at zero
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt <= '0;
    end else if (load) begin
      cnt <= load_val;
    end else if (cnt != '0) begin
      cnt <= cnt - 1'b1;
    end
  end

  // Row-active time, restarted by activate only
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ras_cnt <= '0;
    end else if (load && (cmd == ddr_timing_pkg::CMD_ACT)) begin
      ras_cnt <= LD_RAS;
    end else if (ras_cnt != '0) begin
      ras_cnt <= ras_cnt - 1'b1;
    end
  end

  // Constraint currently tracked by this bank
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      delay_code <= ddr_timing_pkg::CODE_NONE;
    end else if (load) begin
      case (cmd)
        ddr_timing_pkg::CMD_ACT: delay_code <= ddr_timing_pkg::CODE_ACTIVE_TO_READ_WRITE;
        ddr_timing_pkg::CMD_RD:  delay_code <= ddr_timing_pkg::CODE_READ_TO_PRECHARGE;
        ddr_timing_pkg::CMD_WR:  delay_code <= ddr_timing_pkg::CODE_WRITE_TO_PRECHARGE;
        default:                 delay_code <= ddr_timing_pkg::CODE_PRECHARGE_TO_ACTIVE;
      endcase
    end
  end

  assign ready    = (cnt == '0);
  assign ras_done = (ras_cnt == '0);

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  // The gate must never issue into a running delay
  a_load_when_ready : assert property (
    @(posedge clk) disable iff (!rst_n)
    load |-> ready
  );

endmodule

/* hdl/bank_issue_gate.sv */
// Issue gate for the pending command
// Combinational decision in the cycle req_valid is high
// Illegal commands for the row state are rejected at once, even if timers run
// Legal commands wait until the bank timer is ready
// Precharge also waits for the row-active time

`timescale 1ns/1ps

module bank_issue_gate #(
  parameter int NUM_BANKS = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           req_valid,
  input  ddr_timing_pkg::ddr_cmd_t       req_cmd,
  input  logic [$clog2(NUM_BANKS)-1:0]   req_bank,
  input  logic [NUM_BANKS-1:0]           ready,
  input  logic [NUM_BANKS-1:0]           ras_done,
  output logic                           grant,
  output logic                           reject,
  output logic [NUM_BANKS-1:0]           bank_load
);

  logic [NUM_BANKS-1:0] open_row;
  logic                 bank_open;
  logic                 is_act;
  logic                 is_pre;
  logic                 legal;
  logic                 timing_ok;

  ////////////////////////////////////////////////////////////
  // Decision
  ////////////////////////////////////////////////////////////

  assign bank_open = open_row[req_bank];
  assign is_act    = (req_cmd == ddr_timing_pkg::CMD_ACT);
  assign is_pre    = (req_cmd == ddr_timing_pkg::CMD_PRE);

  // Activate needs a closed row, everything else an open one
  assign legal = is_act ? !bank_open : bank_open;

  // Bank delay expired; precharge also needs tRAS
  assign timing_ok = ready[req_bank] && (!is_pre || ras_done[req_bank]);

  assign grant  = req_valid && legal && timing_ok;
  assign reject = req_valid && !legal;

  // One-hot load strobe for the target timer
  always_comb begin
    bank_load = '0;
    if (grant) begin
      bank_load[req_bank] = 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Row state
  ////////////////////////////////////////////////////////////

  // Open on activate, closed on precharge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      open_row <= '0;
    end else if (grant && is_act) begin
      open_row[req_bank] <= 1'b1;
    end else if (grant && is_pre) begin
      open_row[req_bank] <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////

  a_grant_reject_excl : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(grant && reject)
  );

  // The port drops the request right after a decision
  a_single_decision : assert property (
    @(posedge clk) disable iff (!rst_n)
    (grant || reject) |=> !req_valid
  );

endmodule

/* hdl/ddr_cmd_driver.sv */
// DDR command output stage
// A grant becomes a one-cycle command on the next clock edge
// Command and bank hold their last value while valid is low
// Issue count wraps at 16 bits

`timescale 1ns/1ps

module ddr_cmd_driver #(
  parameter int NUM_BANKS = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  input  logic                           grant,
  input  ddr_timing_pkg::ddr_cmd_t       req_cmd,
  input  logic [$clog2(NUM_BANKS)-1:0]   req_bank,
  output logic                           ddr_cmd_valid,
  output ddr_timing_pkg::ddr_cmd_t       ddr_cmd,
  output logic [$clog2(NUM_BANKS)-1:0]   ddr_bank,
  output logic [15:0]                    issue_count
);

  ////////////////////////////////////////////////////////////
  // Command output
  ////////////////////////////////////////////////////////////

  // Strobe for exactly one cycle per grant
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ddr_cmd_valid <= 1'b0;
    end else begin
      ddr_cmd_valid <= grant;
    end
  end

  // Payload follows the strobe
  always_ff @(posedge clk) begin
    if (grant) begin
      ddr_cmd  <= req_cmd;
      ddr_bank <= req_bank;
    end
  end

  ////////////////////////////////////////////////////////////
  // Issue counter
  ////////////////////////////////////////////////////////////

  // Counts grants and wraps at 16 bits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      issue_count <= '0;
    end else if (grant) begin
      issue_count <= issue_count + 16'd1;
    end
  end

  // Valid pulses never stretch past one cycle
  a_valid_pulse : assert property (
    @(posedge clk) disable iff (!rst_n)
    ddr_cmd_valid |=> !ddr_cmd_valid
  );

endmodule

/* hdl/ddr_bank_sched_top.sv */
// Bank timing scheduler top level
// APB port, per-bank timers, issue gate and command driver
// No inter-bank constraints; each bank is timed on its own
// NUM_BANKS up to 8, limited by the bank field of the command word

`timescale 1ns/1ps

module ddr_bank_sched_top #(
  parameter int NUM_BANKS = 8
) (
  input  logic                           clk,
  input  logic                           rst_n,
  // APB slave
  input  logic                           psel,
  input  logic                           penable,
  input  logic                           pwrite,
  input  logic [3:0]                     paddr,
  input  logic [31:0]                    pwdata,
  output logic [31:0]                    prdata,
  output logic                           pready,
  output logic                           pslverr,
  // DDR command output
  output logic                           ddr_cmd_valid,
  output ddr_timing_pkg::ddr_cmd_t       ddr_cmd,
  output logic [$clog2(NUM_BANKS)-1:0]   ddr_bank
);

  localparam int BANK_BITS = $clog2(NUM_BANKS);

  logic                       req_valid;
  ddr_timing_pkg::ddr_cmd_t   req_cmd;
  logic [BANK_BITS-1:0]       req_bank;
  logic                       req_bc4;
  logic                       grant;
  logic                       reject;
  logic [NUM_BANKS-1:0]       bank_load;
  logic [NUM_BANKS-1:0]       ready;
  logic [NUM_BANKS-1:0]       ras_done;
  logic [15:0]                issue_count;

  ddr_apb_cmd_port #(.NUM_BANKS(NUM_BANKS)) u_port (
    .clk(clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .grant(grant), .reject(reject), .issue_count(issue_count),
    .req_valid(req_valid), .req_cmd(req_cmd), .req_bank(req_bank), .req_bc4(req_bc4)
  );

  // One timer per bank; delay codes stay internal
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    bank_timer u_timer (
      .clk(clk), .rst_n(rst_n), .load(bank_load[b]), .cmd(req_cmd), .bc4(req_bc4),
      .ready(ready[b]), .ras_done(ras_done[b]), .delay_code()
    );
  end

  bank_issue_gate #(.NUM_BANKS(NUM_BANKS)) u_gate (
    .clk(clk), .rst_n(rst_n), .req_valid(req_valid), .req_cmd(req_cmd),
    .req_bank(req_bank), .ready(ready), .ras_done(ras_done),
    .grant(grant), .reject(reject), .bank_load(bank_load)
  );

  ddr_cmd_driver #(.NUM_BANKS(NUM_BANKS)) u_driver (
    .clk(clk), .rst_n(rst_n), .grant(grant), .req_cmd(req_cmd), .req_bank(req_bank),
    .ddr_cmd_valid(ddr_cmd_valid), .ddr_cmd(ddr_cmd), .ddr_bank(ddr_bank),
    .issue_count(issue_count)
  );

endmodule

/* dv/tb_ddr_bank_sched.sv */
// Table-driven testbench for the DDR bank scheduler
// Each table entry is one APB command write; a per-bank model predicts the grant cycle
// Table banks 8 and 9 stand for two distinct banks picked at random from 2 to 7
// Inputs change on the rising edge, outputs are sampled on the falling edge
// Row state after reset is assumed closed in every bank

`timescale 1ns/1ps

module tb_ddr_bank_sched;

  localparam int NUM_BANKS = 8;
  localparam int MAX_ENT   = 32;
  localparam int BANK_A    = 8;
  localparam int BANK_B    = 9;

  logic                     clk;
  logic                     rst_n;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [3:0]               paddr;
  logic [31:0]              pwdata;
  logic [31:0]              prdata;
  logic                     pready;
  logic                     pslverr;
  logic                     ddr_cmd_valid;
  ddr_timing_pkg::ddr_cmd_t ddr_cmd;
  logic [2:0]               ddr_bank;

  // Stimulus table
  int                       ent_test [MAX_ENT];
  ddr_timing_pkg::ddr_cmd_t ent_cmd  [MAX_ENT];
  int                       ent_bank [MAX_ENT];
  logic                     ent_bc4  [MAX_ENT];
  logic                     ent_err  [MAX_ENT];
  int                       n_ent = 0;

  // Per-bank model in cycle numbers of the DDR pulses
  logic row_open   [NUM_BANKS];
  logic has_hist   [NUM_BANKS];
  int   last_pulse [NUM_BANKS];
  int   last_delay [NUM_BANKS];
  int   act_pulse  [NUM_BANKS];
  int   issued = 0;

  // Monitor queues
  int pulse_cyc[$];
  int pulse_cmd[$];
  int pulse_bank[$];

  int          cyc = 0;
  int          cycle_limit = 100;
  int          errors = 0;
  int          n_checks = 0;
  int          n_tests = 0;
  int          n_failed = 0;
  int          test_err_base = 0;
  int          bank_a;
  int          bank_b;
  logic [31:0] lfsr = 32'h2831;

  ddr_bank_sched_top #(.NUM_BANKS(NUM_BANKS)) u_dut (
    .clk(clk), .rst_n(rst_n),
    .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr), .pwdata(pwdata),
    .prdata(prdata), .pready(pready), .pslverr(pslverr),
    .ddr_cmd_valid(ddr_cmd_valid), .ddr_cmd(ddr_cmd), .ddr_bank(ddr_bank)
  );

  ////////////////////////////////////////////////////////////
  // Clock, cycle count, watchdog, monitor
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) cyc <= cyc + 1;

  initial begin
    while (cyc <= cycle_limit) @(negedge clk);
    $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
    $display("Something failed");
    $finish;
  end

  // Timestamp every DDR command pulse
  always @(negedge clk) begin
    if (rst_n && ddr_cmd_valid) begin
      pulse_cyc.push_back(cyc);
      pulse_cmd.push_back(int'(ddr_cmd));
      pulse_bank.push_back(int'(ddr_bank));
    end
  end

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] galois_step(input logic [31:0] s);
    logic lsb;
    lsb = s[0];
    s = s >> 1;
    if (lsb) s = s ^ 32'h80200003;
    return s;
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int k = 0; k < n; k++) begin
      val = (val << 1) | int'(lfsr[0]);
      lfsr = galois_step(lfsr);
    end
  endtask

  task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                          input string msg);
    n_checks++;
    if (actual !== expected) begin
      errors++;
      $display("ERR %0d ns: %s (got %0d, expected %0d)", $time, msg, actual, expected);
    end
  endtask

  // Minimum spacing after a command by the DDR timing rules
  function automatic int required_gap(input ddr_timing_pkg::ddr_cmd_t cmd, input logic bc4);
    case (cmd)
      ddr_timing_pkg::CMD_ACT: return ddr_timing_pkg::CYCLE_TRCD;
      ddr_timing_pkg::CMD_RD:  return ddr_timing_pkg::CYCLE_TRTP;
      ddr_timing_pkg::CMD_WR:  return ddr_timing_pkg::CYCLE_WL + ddr_timing_pkg::CYCLE_TWR
                                      + (bc4 ? 2 : 4);
      default:                 return ddr_timing_pkg::CYCLE_TRP;
    endcase
  endfunction

  task automatic add_entry(input int test, input ddr_timing_pkg::ddr_cmd_t cmd,
                           input int bank, input logic bc4, input logic err);
    ent_test[n_ent] = test;
    ent_cmd[n_ent]  = cmd;
    ent_bank[n_ent] = bank;
    ent_bc4[n_ent]  = bc4;
    ent_err[n_ent]  = err;
    n_ent++;
  endtask

  function automatic string test_name(input int id);
    case (id)
      0:       return "reset";
      1:       return "same bank ACT RD PRE ACT";
      2:       return "write BL8 and BC4";
      3:       return "illegal commands";
      4:       return "interleaved banks";
      default: return "status read";
    endcase
  endfunction

  task automatic finish_test(input int id);
    int e;
    e = errors - test_err_base;
    n_tests++;
    if (e != 0) n_failed++;
    $display("test %0d %s %s, %0d errors",
             id, test_name(id), (e == 0) ? "PASS" : "FAIL", e);
    test_err_base = errors;
  endtask

  // One APB transfer; returns the first access cycle and the completion cycle
  task automatic apb_access(input logic wr, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err,
                            output int acc, output int rdy);
    @(posedge clk);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk);
    penable <= 1'b1;
    @(negedge clk);
    acc = cyc;
    while (!pready) @(negedge clk);
    rdy   = cyc;
    rdata = prdata;
    err   = pslverr;
    @(posedge clk);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          idle;
    int          b;
    int          r;
    int          acc;
    int          rdy;
    int          early;
    logic        legal;
    logic        err;
    logic [31:0] rdata;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    for (int k = 0; k < NUM_BANKS; k++) begin
      row_open[k] = 1'b0;
      has_hist[k] = 1'b0;
    end

    // Interleave banks are distinct and avoid the open rows of banks 0 and 1
    take_bits(3, r);
    bank_a = 2 + (r % 6);
    take_bits(3, r);
    bank_b = 2 + (((bank_a - 2) + 1 + (r % 5)) % 6);

    add_entry(1, ddr_timing_pkg::CMD_ACT, 0, 1'b0, 1'b0);
    add_entry(1, ddr_timing_pkg::CMD_RD,  0, 1'b0, 1'b0);
    add_entry(1, ddr_timing_pkg::CMD_PRE, 0, 1'b0, 1'b0);
    add_entry(1, ddr_timing_pkg::CMD_ACT, 0, 1'b0, 1'b0);
    add_entry(2, ddr_timing_pkg::CMD_ACT, 1, 1'b0, 1'b0);
    add_entry(2, ddr_timing_pkg::CMD_WR,  1, 1'b0, 1'b0);
    add_entry(2, ddr_timing_pkg::CMD_PRE, 1, 1'b0, 1'b0);
    add_entry(2, ddr_timing_pkg::CMD_ACT, 1, 1'b0, 1'b0);
    add_entry(2, ddr_timing_pkg::CMD_WR,  1, 1'b1, 1'b0);
    add_entry(2, ddr_timing_pkg::CMD_PRE, 1, 1'b0, 1'b0);
    add_entry(3, ddr_timing_pkg::CMD_RD,  2, 1'b0, 1'b1);
    add_entry(3, ddr_timing_pkg::CMD_ACT, 0, 1'b0, 1'b1);
    add_entry(3, ddr_timing_pkg::CMD_WR,  3, 1'b1, 1'b1);
    add_entry(3, ddr_timing_pkg::CMD_PRE, 5, 1'b0, 1'b1);
    add_entry(4, ddr_timing_pkg::CMD_ACT, BANK_A, 1'b0, 1'b0);
    add_entry(4, ddr_timing_pkg::CMD_ACT, BANK_B, 1'b0, 1'b0);
    add_entry(4, ddr_timing_pkg::CMD_RD,  BANK_A, 1'b0, 1'b0);
    add_entry(4, ddr_timing_pkg::CMD_WR,  BANK_B, 1'b0, 1'b0);
    add_entry(4, ddr_timing_pkg::CMD_PRE, BANK_A, 1'b0, 1'b0);
    add_entry(4, ddr_timing_pkg::CMD_PRE, BANK_B, 1'b0, 1'b0);
    add_entry(4, ddr_timing_pkg::CMD_ACT, BANK_A, 1'b0, 1'b0);
    cycle_limit = 40 * n_ent + 100;

    // Outputs stay low while reset is held for 4 cycles
    repeat (4) begin
      @(negedge clk);
      check_eq(pready, 1'b0, "pready high during reset");
      check_eq(pslverr, 1'b0, "pslverr high during reset");
      check_eq(ddr_cmd_valid, 1'b0, "ddr_cmd_valid high during reset");
      check_eq(prdata, 32'd0, "prdata not zero during reset");
    end
    @(posedge clk);
    rst_n <= 1'b1;
    finish_test(0);

    for (int i = 0; i < n_ent; i++) begin
      if (i > 0 && ent_test[i] != ent_test[i-1]) finish_test(ent_test[i-1]);
      take_bits(2, idle);
      repeat (idle) @(posedge clk);
      b = (ent_bank[i] == BANK_A) ? bank_a : (ent_bank[i] == BANK_B) ? bank_b : ent_bank[i];

      // Model legality and earliest grant cycle for this bank
      legal = (ent_cmd[i] == ddr_timing_pkg::CMD_ACT) ? !row_open[b] : row_open[b];
      check_eq(!legal, ent_err[i], $sformatf("entry %0d: table disagrees with row model", i));
      early = has_hist[b] ? last_pulse[b] - 1 + last_delay[b] : 0;
      if (ent_cmd[i] == ddr_timing_pkg::CMD_PRE && row_open[b]) begin
        early = (act_pulse[b] - 1 + ddr_timing_pkg::CYCLE_TRAS > early) ?
                act_pulse[b] - 1 + ddr_timing_pkg::CYCLE_TRAS : early;
      end

      apb_access(1'b1, ddr_timing_pkg::ADDR_CMD,
                 (32'(ent_bc4[i]) << 8) | (32'(b) << 4) | 32'(ent_cmd[i]),
                 rdata, err, acc, rdy);
      // Let the monitor see the pulse that follows pready
      @(posedge clk);

      check_eq(err, ent_err[i], $sformatf("entry %0d: pslverr", i));
      if (ent_err[i]) begin
        check_eq(rdy, acc + 1, $sformatf("entry %0d: reject latency", i));
        check_eq(pulse_cyc.size(), 0, $sformatf("entry %0d: rejected command issued", i));
      end else begin
        issued++;
        check_eq(rdy, (early > acc + 1) ? early : acc + 1,
                 $sformatf("entry %0d: grant cycle", i));
        if (i == 0) check_eq(rdy, acc + 1, "first ACT after reset delayed");
        check_eq(pulse_cyc.size(), 1, $sformatf("entry %0d: DDR pulse count", i));
        if (pulse_cyc.size() > 0) begin
          check_eq(pulse_cyc[0], rdy + 1, $sformatf("entry %0d: pulse not after pready", i));
          check_eq(pulse_cmd[0], int'(ent_cmd[i]), $sformatf("entry %0d: DDR command", i));
          check_eq(pulse_bank[0], b, $sformatf("entry %0d: DDR bank", i));
          if (has_hist[b]) begin
            check_eq(pulse_cyc[0] - last_pulse[b] >= last_delay[b], 1'b1,
                     $sformatf("entry %0d: gap shorter than bank delay", i));
          end
          if (ent_cmd[i] == ddr_timing_pkg::CMD_PRE) begin
            check_eq(pulse_cyc[0] - act_pulse[b] >= ddr_timing_pkg::CYCLE_TRAS, 1'b1,
                     $sformatf("entry %0d: PRE before tRAS", i));
          end
          // Model update on a granted command
          has_hist[b]   = 1'b1;
          last_pulse[b] = pulse_cyc[0];
          last_delay[b] = required_gap(ent_cmd[i], ent_bc4[i]);
          if (ent_cmd[i] == ddr_timing_pkg::CMD_ACT) begin
            row_open[b]  = 1'b1;
            act_pulse[b] = pulse_cyc[0];
          end
          if (ent_cmd[i] == ddr_timing_pkg::CMD_PRE) row_open[b] = 1'b0;
        end
      end
      pulse_cyc.delete();
      pulse_cmd.delete();
      pulse_bank.delete();
    end
    finish_test(ent_test[n_ent-1]);

    // Status read completes at once with the model's issue count
    apb_access(1'b0, ddr_timing_pkg::ADDR_STATUS, 32'd0, rdata, err, acc, rdy);
    check_eq(rdy, acc, "status read had wait states");
    check_eq(err, 1'b0, "status read pslverr");
    check_eq(rdata[15:0], issued, "issued count");
    check_eq(rdata[31], 1'b0, "pending flag set");
    finish_test(5);

    $display("Summary: %0d tests, %0d failed, %0d checks, %0d errors",
             n_tests, n_failed, n_checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

/* ddr_bank_sched_top.f */
hdl/ddr_timing_pkg.sv
hdl/ddr_apb_cmd_port.sv
hdl/bank_timer.sv
hdl/bank_issue_gate.sv
hdl/ddr_cmd_driver.sv
hdl/ddr_bank_sched_top.sv
dv/tb_ddr_bank_sched.sv
